// ==== design/asic_pkg.sv ====
package asic_pkg;

    ////////////////////
    // Shared types

    typedef logic [9:0]  hcount_t;
    typedef logic [8:0]  vcount_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] cpu_addr_t;
    typedef logic [4:0]  page_t;
    typedef logic [18:0] ram_addr_t;

    // VMPR bits 6:5
    typedef enum logic [1:0] {
        MODE_1 = 2'd0,
        MODE_2 = 2'd1,
        MODE_3 = 2'd2,
        MODE_4 = 2'd3
    } screen_mode_t;

    ////////////////////
    // Horizontal timing, in pixel clocks

    localparam hcount_t H_ACTIVE = 10'd512;
    localparam hcount_t R_BORDER = 10'd64;
    localparam hcount_t H_FPORCH = 10'd16;
    localparam hcount_t H_SYNC   = 10'd64;
    localparam hcount_t H_BPORCH = 10'd64;
    localparam hcount_t L_BORDER = 10'd48;

    localparam hcount_t H_TOTAL = H_ACTIVE + R_BORDER + H_FPORCH + H_SYNC + H_BPORCH + L_BORDER;

    // Line sync sits right after the right border
    localparam hcount_t H_SYNC_START = R_BORDER + H_FPORCH;
    localparam hcount_t H_SYNC_END   = H_SYNC_START + H_SYNC;

    // Fetch window opens here, interrupt window closes here
    localparam hcount_t H_FETCH_START = 10'd256;

    ////////////////////
    // Vertical timing, in scanlines

    localparam vcount_t V_ACTIVE = 9'd192;
    localparam vcount_t B_BORDER = 9'd48;
    localparam vcount_t V_FPORCH = 9'd4;
    localparam vcount_t V_SYNC   = 9'd4;
    localparam vcount_t V_BPORCH = 9'd16;
    localparam vcount_t T_BORDER = 9'd48;

    localparam vcount_t V_TOTAL = V_ACTIVE + B_BORDER + V_FPORCH + V_SYNC + V_BPORCH + T_BORDER;

    localparam vcount_t V_SYNC_START = V_ACTIVE + B_BORDER + V_FPORCH;
    localparam vcount_t V_SYNC_END   = V_SYNC_START + V_SYNC;

    ////////////////////
    // I/O ports, low address byte

    localparam byte_t PORT_BORDER  = 8'd254;
    localparam byte_t PORT_VMPR    = 8'd252;
    localparam byte_t PORT_HMPR    = 8'd251;
    localparam byte_t PORT_LMPR    = 8'd250;
    localparam byte_t PORT_LINEINT = 8'd249;   // status on read

    // Any value past the last active line disables the line interrupt
    localparam byte_t LINEINT_OFF = 8'hFF;

    ////////////////////
    // Memory map

    localparam cpu_addr_t SECTION_A_END   = 16'h4000;
    localparam cpu_addr_t SECTION_D_START = 16'hC000;
    localparam cpu_addr_t EXT_MEM_START   = 16'h8000;

    // Contention, 16-clock slots
    localparam logic [3:0] CONT_SLOT_LEN   = 4'd10;
    localparam logic [5:0] MODE1_CONT_COLS = 6'd40;

endpackage

// ==== design/asic_top.sv ====
module asic_top
    import asic_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // CPU bus
    input  logic      mreq_n,
    input  logic      iorq_n,
    input  logic      rd_n,
    input  logic      wr_n,
    input  cpu_addr_t cpuaddr,
    input  byte_t     data_from_cpu,
    output byte_t     data_to_cpu,
    output logic      data_enable_n,
    output logic      wait_n,
    // Memory
    output ram_addr_t cpuramaddr,
    output logic      ramwr_n,
    output logic      romcs_n,
    output logic      ramcs_n,
    output logic      asic_is_using_ram,
    // Audio and keyboard
    input  logic      ear,
    output logic      mic,
    output logic      beep,
    input  byte_t     keyboard,
    // Video
    output logic      csync,
    output logic      int_n
);

    hcount_t      hc;
    vcount_t      vc;
    byte_t        lineint;
    screen_mode_t screen_mode;
    logic         screen_off;
    page_t        low_page;
    page_t        high_page;
    logic         rom_a_en;
    logic         rom_d_en;
    logic         write_protect_a;
    logic         external_memory;
    logic         vint_n;
    logic         rint_n;
    logic         rom_access;

    raster_timer u_raster_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .hc    (hc),
        .vc    (vc)
    );

    sync_int_gen u_sync_int_gen (
        .hc      (hc),
        .vc      (vc),
        .lineint (lineint),
        .csync   (csync),
        .int_n   (int_n),
        .vint_n  (vint_n),
        .rint_n  (rint_n)
    );

    contention_gen u_contention_gen (
        .hc                (hc),
        .vc                (vc),
        .screen_mode       (screen_mode),
        .screen_off        (screen_off),
        .mreq_n            (mreq_n),
        .iorq_n            (iorq_n),
        .rom_access        (rom_access),
        .wait_n            (wait_n),
        .asic_is_using_ram (asic_is_using_ram)
    );

    io_ports u_io_ports (
        .clk             (clk),
        .rst_n           (rst_n),
        .iorq_n          (iorq_n),
        .rd_n            (rd_n),
        .wr_n            (wr_n),
        .cpuaddr         (cpuaddr),
        .data_from_cpu   (data_from_cpu),
        .ear             (ear),
        .keyboard        (keyboard),
        .vint_n          (vint_n),
        .rint_n          (rint_n),
        .data_to_cpu     (data_to_cpu),
        .data_enable_n   (data_enable_n),
        .mic             (mic),
        .beep            (beep),
        .lineint         (lineint),
        .screen_mode     (screen_mode),
        .screen_off      (screen_off),
        .low_page        (low_page),
        .high_page       (high_page),
        .rom_a_en        (rom_a_en),
        .rom_d_en        (rom_d_en),
        .write_protect_a (write_protect_a),
        .external_memory (external_memory)
    );

    mem_mapper u_mem_mapper (
        .mreq_n          (mreq_n),
        .wr_n            (wr_n),
        .cpuaddr         (cpuaddr),
        .low_page        (low_page),
        .high_page       (high_page),
        .rom_a_en        (rom_a_en),
        .rom_d_en        (rom_d_en),
        .write_protect_a (write_protect_a),
        .external_memory (external_memory),
        .romcs_n         (romcs_n),
        .ramcs_n         (ramcs_n),
        .ramwr_n         (ramwr_n),
        .cpuramaddr      (cpuramaddr),
        .rom_access      (rom_access)
    );

endmodule

// ==== design/contention_gen.sv ====
module contention_gen
    import asic_pkg::*;
(
    input  hcount_t      hc,
    input  vcount_t      vc,
    input  screen_mode_t screen_mode,
    input  logic         screen_off,
    input  logic         mreq_n,
    input  logic         iorq_n,
    input  logic         rom_access,
    output logic         wait_n,
    output logic         asic_is_using_ram
);

    logic [3:0] slot;
    logic       slot_busy;
    logic       slot_edge;
    logic       fetching;
    logic       mem_contention;
    logic       io_contention;

    assign slot = hc[3:0];

    // First ten clocks of each slot belong to the video side
    assign slot_busy = (slot < CONT_SLOT_LEN);

    // Clocks 0, 1, 8 and 9 only
    assign slot_edge = (slot == 4'd0) || (slot == 4'd1) || (slot == 4'd8) || (slot == 4'd9);

    // Pixel fetch, active lines right half
    assign fetching = (vc < V_ACTIVE) && (hc >= H_FETCH_START) && !screen_off;

    ////////////////////
    // Contention windows

    always_comb begin
        io_contention  = 1'b0;
        mem_contention = 1'b0;

        if (screen_off) begin
            io_contention = slot_edge;
        end else begin
            io_contention = slot_busy;
        end

        if (fetching) begin
            mem_contention = slot_busy;
        end else begin
            mem_contention = slot_edge;
        end

        // Mode 1 also steals slots from the left part of each line
        if ((screen_mode == MODE_1) && slot_busy && (hc[9:4] < MODE1_CONT_COLS)) begin
            mem_contention = 1'b1;
        end
    end

    ////////////////////
    // CPU wait line, ROM cycles run free

    always_comb begin
        wait_n = 1'b1;
        if (!rom_access) begin
            if (mem_contention && !mreq_n) begin
                wait_n = 1'b0;
            end else if (io_contention && !iorq_n) begin
                wait_n = 1'b0;
            end
        end
    end

    assign asic_is_using_ram = mem_contention & fetching;

    // No wait state without a bus cycle
    a_wait_needs_cycle: assert property (
        @(hc) (mreq_n && iorq_n) |-> wait_n
    );

endmodule

// ==== design/io_ports.sv ====
module io_ports
    import asic_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         iorq_n,
    input  logic         rd_n,
    input  logic         wr_n,
    input  cpu_addr_t    cpuaddr,
    input  byte_t        data_from_cpu,
    input  logic         ear,
    input  byte_t        keyboard,
    input  logic         vint_n,
    input  logic         rint_n,
    output byte_t        data_to_cpu,
    output logic         data_enable_n,
    output logic         mic,
    output logic         beep,
    output byte_t        lineint,
    output screen_mode_t screen_mode,
    output logic         screen_off,
    output page_t        low_page,
    output page_t        high_page,
    output logic         rom_a_en,
    output logic         rom_d_en,
    output logic         write_protect_a,
    output logic         external_memory
);

    byte_t vmpr;
    byte_t hmpr;
    byte_t lmpr;
    byte_t border;
    byte_t port;
    logic  io_write;
    logic  io_read;

    assign port     = cpuaddr[7:0];
    assign io_write = !iorq_n && !wr_n;
    assign io_read  = !iorq_n && !rd_n;

    ////////////////////
    // Register writes

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vmpr    <= '0;
            hmpr    <= '0;
            lmpr    <= '0;
            border  <= '0;
            lineint <= LINEINT_OFF;
        end else if (io_write) begin
            case (port)
                PORT_BORDER:  border  <= data_from_cpu;
                PORT_VMPR:    vmpr    <= data_from_cpu;
                PORT_HMPR:    hmpr    <= data_from_cpu;
                PORT_LMPR:    lmpr    <= data_from_cpu;
                PORT_LINEINT: lineint <= data_from_cpu;
                default: ;
            endcase
        end
    end

    ////////////////////
    // Control fields

    assign screen_mode = screen_mode_t'(vmpr[6:5]);

    // Border bit 7 blanks the screen in modes 3 and 4 only
    assign screen_off = border[7] && ((screen_mode == MODE_3) || (screen_mode == MODE_4));

    assign low_page        = lmpr[4:0];
    assign rom_a_en        = ~lmpr[5];
    assign rom_d_en        = lmpr[6];
    assign write_protect_a = lmpr[7];

    assign high_page       = hmpr[4:0];
    assign external_memory = hmpr[7];

    assign mic  = border[3];
    assign beep = border[4];

    ////////////////////
    // Read multiplexer

    always_comb begin
        data_enable_n = 1'b1;
        data_to_cpu   = 8'hFF;
        if (io_read) begin
            data_enable_n = 1'b0;
            case (port)
                PORT_BORDER:  data_to_cpu = {screen_off, ear, 1'b0, keyboard[4:0]};
                // Status, interrupt flags active low
                PORT_LINEINT: data_to_cpu = {keyboard[7:5], 1'b1, vint_n, 2'b11, rint_n};
                PORT_VMPR:    data_to_cpu = vmpr;
                PORT_HMPR:    data_to_cpu = hmpr;
                PORT_LMPR:    data_to_cpu = lmpr;
                default: begin
                    // Not ours, leave the bus alone
                    data_enable_n = 1'b1;
                end
            endcase
        end
    end

    // Data bus is driven only during an I/O read
    a_read_only_drive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !data_enable_n |-> (!iorq_n && !rd_n)
    );

endmodule

// ==== design/mem_mapper.sv ====
module mem_mapper
    import asic_pkg::*;
(
    input  logic      mreq_n,
    input  logic      wr_n,
    input  cpu_addr_t cpuaddr,
    input  page_t     low_page,
    input  page_t     high_page,
    input  logic      rom_a_en,
    input  logic      rom_d_en,
    input  logic      write_protect_a,
    input  logic      external_memory,
    output logic      romcs_n,
    output logic      ramcs_n,
    output logic      ramwr_n,
    output ram_addr_t cpuramaddr,
    output logic      rom_access
);

    logic  in_rom_a;
    logic  in_rom_d;
    logic  in_ext;
    page_t page;

    assign in_rom_a = (cpuaddr < SECTION_A_END) && rom_a_en;
    assign in_rom_d = (cpuaddr >= SECTION_D_START) && rom_d_en;

    // Upper 32 KiB handed over to external memory
    assign in_ext = (cpuaddr >= EXT_MEM_START) && external_memory;

    ////////////////////
    // Chip selects

    always_comb begin
        romcs_n = 1'b1;
        ramcs_n = 1'b1;
        if (!mreq_n) begin
            if (in_rom_a || in_rom_d) begin
                romcs_n = 1'b0;
            end else if (!in_ext) begin
                ramcs_n = 1'b0;
            end
        end
    end

    assign rom_access = ~romcs_n;

    ////////////////////
    // Paging, one page per 16K bank

    always_comb begin
        case (cpuaddr[15:14])
            2'd0:    page = low_page;
            2'd1:    page = low_page + 5'd1;
            2'd2:    page = high_page;
            default: page = high_page + 5'd1;
        endcase
    end

    assign cpuramaddr = {page, cpuaddr[13:0]};

    // Section A can be made read only
    always_comb begin
        ramwr_n = ramcs_n | wr_n;
        if ((cpuaddr[15:14] == 2'd0) && write_protect_a) begin
            ramwr_n = 1'b1;
        end
    end

endmodule

// ==== design/raster_timer.sv ====
module raster_timer
    import asic_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    output hcount_t hc,
    output vcount_t vc
);

    logic line_end;
    logic frame_end;

    assign line_end  = (hc == H_TOTAL - 10'd1);
    assign frame_end = (vc == V_TOTAL - 9'd1);

    ////////////////////
    // Pixel and scanline counters

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hc <= '0;
            vc <= '0;
        end else begin
            if (line_end) begin
                hc <= '0;
                // Next scanline, wrap at the end of the frame
                if (frame_end) begin
                    vc <= '0;
                end else begin
                    vc <= vc + 9'd1;
                end
            end else begin
                hc <= hc + 10'd1;
            end
        end
    end

    // Counters never leave the raster
    a_raster_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (hc < H_TOTAL) && (vc < V_TOTAL)
    );

endmodule

// ==== design/sync_int_gen.sv ====
module sync_int_gen
    import asic_pkg::*;
(
    input  hcount_t hc,
    input  vcount_t vc,
    input  byte_t   lineint,
    output logic    csync,
    output logic    int_n,
    output logic    vint_n,
    output logic    rint_n
);

    logic in_hsync;
    logic in_vsync;
    logic int_window;
    logic lineint_valid;

    assign in_hsync   = (hc >= H_SYNC_START) && (hc < H_SYNC_END);
    assign in_vsync   = (vc >= V_SYNC_START) && (vc < V_SYNC_END);

    // Interrupts last for the left half of the line
    assign int_window = (hc < H_FETCH_START);

    // Only lines inside the active area can raise a line interrupt
    assign lineint_valid = ({1'b0, lineint} < V_ACTIVE);

    ////////////////////
    // Composite sync

    always_comb begin
        csync = 1'b1;
        if (in_hsync) begin
            csync = 1'b0;
        end
        // Serrated vertical sync
        if (in_vsync) begin
            csync = ~csync;
        end
    end

    ////////////////////
    // Frame and line interrupts

    always_comb begin
        vint_n = 1'b1;
        rint_n = 1'b1;
        if ((vc == V_SYNC_START) && int_window) begin
            vint_n = 1'b0;
        end
        if (lineint_valid && (vc == {1'b0, lineint}) && int_window) begin
            rint_n = 1'b0;
        end
    end

    assign int_n = vint_n & rint_n;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f sources.f --top-module asic_tb

output=$(./obj_dir/Vasic_tb || true)
echo "$output"

if echo "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
else
    exit 1
fi

// ==== sim/asic_tb.sv ====
module asic_tb
    import asic_pkg::*;
();

    localparam int FRAME_CYCLES = int'(V_TOTAL) * int'(H_TOTAL);
    localparam longint WATCHDOG_TIME = (2 * longint'(FRAME_CYCLES) + 20000) * 40;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic      clk;
    logic      rst_n;
    logic      mreq_n;
    logic      iorq_n;
    logic      rd_n;
    logic      wr_n;
    cpu_addr_t cpuaddr;
    byte_t     data_from_cpu;
    byte_t     data_to_cpu;
    logic      data_enable_n;
    logic      wait_n;
    ram_addr_t cpuramaddr;
    logic      ramwr_n;
    logic      romcs_n;
    logic      ramcs_n;
    logic      asic_is_using_ram;
    logic      ear;
    logic      mic;
    logic      beep;
    byte_t     keyboard;
    logic      csync;
    logic      int_n;

    // Reference model state
    hcount_t     m_hc;
    vcount_t     m_vc;
    byte_t       m_vmpr;
    byte_t       m_hmpr;
    byte_t       m_lmpr;
    byte_t       m_border;
    byte_t       m_lineint;
    logic        checking;
    string       test_name;
    logic [31:0] lfsr_state;
    byte_t       line_sel;

    asic_top UUT (.*);

    always #20 clk = ~clk;

    ////////////////////
    // Random numbers

    function automatic logic rand_bit();
        if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
        end else begin
            lfsr_state = lfsr_state >> 1;
        end
        return lfsr_state[0];
    endfunction

    function automatic byte_t rand_byte();
        byte_t v;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            v = {v[6:0], rand_bit()};
        end
        return v;
    endfunction

    function automatic cpu_addr_t rand_word();
        byte_t hi;
        byte_t lo;
        hi = rand_byte();
        lo = rand_byte();
        return {hi, lo};
    endfunction

    ////////////////////
    // Compare tasks

    task automatic halt_on_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("Error: test %s, %s: expected %b, actual %b",
                     test_name, what, expected, actual);
            halt_on_failure();
        end
    endtask

    task automatic check_byte(input string what, input byte_t expected, input byte_t actual);
        if (expected !== actual) begin
            $display("Error: test %s, %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            halt_on_failure();
        end
    endtask

    task automatic check_ram_addr(input string what, input ram_addr_t expected,
                                  input ram_addr_t actual);
        if (expected !== actual) begin
            $display("Error: test %s, %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            halt_on_failure();
        end
    endtask

    ////////////////////
    // Reference model

    always @(posedge clk) begin
        if (!rst_n) begin
            m_hc      = '0;
            m_vc      = '0;
            m_vmpr    = '0;
            m_hmpr    = '0;
            m_lmpr    = '0;
            m_border  = '0;
            m_lineint = 8'hFF;
        end else begin
            if (!iorq_n && !wr_n) begin
                case (cpuaddr[7:0])
                    PORT_BORDER:  m_border  = data_from_cpu;
                    PORT_VMPR:    m_vmpr    = data_from_cpu;
                    PORT_HMPR:    m_hmpr    = data_from_cpu;
                    PORT_LMPR:    m_lmpr    = data_from_cpu;
                    PORT_LINEINT: m_lineint = data_from_cpu;
                    default: ;
                endcase
            end
            if (m_hc == H_TOTAL - 10'd1) begin
                m_hc = '0;
                m_vc = (m_vc == V_TOTAL - 9'd1) ? 9'd0 : m_vc + 9'd1;
            end else begin
                m_hc = m_hc + 10'd1;
            end
        end
    end

    task automatic check_outputs();
        logic       hsync;
        logic       vsync;
        logic       vint;
        logic       rint;
        logic       scr_off;
        logic       fetch;
        logic       busy;
        logic       edge_slot;
        logic       io_c;
        logic       mem_c;
        logic       rom;
        logic       ram;
        logic [3:0] slot;
        page_t      pg;
        byte_t      exp_data;
        logic       exp_en;

        hsync = (m_hc >= 10'd80) && (m_hc <= 10'd143);
        vsync = (m_vc >= 9'd244) && (m_vc <= 9'd247);
        vint  = (m_vc == 9'd244) && (m_hc < 10'd256);
        rint  = (m_lineint <= 8'd191) && (m_vc == {1'b0, m_lineint}) && (m_hc < 10'd256);
        check_bit("csync", ~(hsync ^ vsync), csync);
        check_bit("int_n", ~(vint | rint), int_n);

        // Contention windows
        scr_off   = m_border[7] & m_vmpr[6];
        fetch     = (m_vc < 9'd192) && (m_hc >= 10'd256) && !scr_off;
        slot      = m_hc[3:0];
        busy      = (slot <= 4'd9);
        edge_slot = (slot == 4'd0) || (slot == 4'd1) || (slot == 4'd8) || (slot == 4'd9);
        io_c      = scr_off ? edge_slot : busy;
        mem_c     = (fetch ? busy : edge_slot)
                    || ((m_vmpr[6:5] == 2'b00) && busy && (m_hc < 10'd640));

        // Memory map
        rom = !mreq_n && (((cpuaddr[15:14] == 2'b00) && !m_lmpr[5])
                          || ((cpuaddr[15:14] == 2'b11) && m_lmpr[6]));
        ram = !mreq_n && !rom && !(cpuaddr[15] && m_hmpr[7]);
        case (cpuaddr[15:14])
            2'b00:   pg = m_lmpr[4:0];
            2'b01:   pg = m_lmpr[4:0] + 5'd1;
            2'b10:   pg = m_hmpr[4:0];
            default: pg = m_hmpr[4:0] + 5'd1;
        endcase

        check_bit("wait_n", rom || !((mem_c && !mreq_n) || (io_c && !iorq_n)), wait_n);
        check_bit("asic_is_using_ram", mem_c && fetch, asic_is_using_ram);
        check_bit("romcs_n", !rom, romcs_n);
        check_bit("ramcs_n", !ram, ramcs_n);
        check_bit("ramwr_n", !(ram && !wr_n) || ((cpuaddr[15:14] == 2'b00) && m_lmpr[7]),
                  ramwr_n);
        check_ram_addr("cpuramaddr", {pg, cpuaddr[13:0]}, cpuramaddr);

        exp_en   = 1'b1;
        exp_data = 8'hFF;
        if (!iorq_n && !rd_n) begin
            exp_en = 1'b0;
            case (cpuaddr[7:0])
                PORT_BORDER:  exp_data = {scr_off, ear, 1'b0, keyboard[4:0]};
                PORT_LINEINT: exp_data = {keyboard[7:5], 1'b1, ~vint, 2'b11, ~rint};
                PORT_VMPR:    exp_data = m_vmpr;
                PORT_HMPR:    exp_data = m_hmpr;
                PORT_LMPR:    exp_data = m_lmpr;
                default:      exp_en   = 1'b1;
            endcase
        end
        check_bit("data_enable_n", exp_en, data_enable_n);
        check_byte("data_to_cpu", exp_data, data_to_cpu);
        check_bit("mic", m_border[3], mic);
        check_bit("beep", m_border[4], beep);
    endtask

    // Outputs are settled half a period after the edge
    always @(negedge clk) begin
        if (checking) begin
            check_outputs();
        end
    end

    ////////////////////
    // Bus cycles

    task automatic idle_cycle();
        mreq_n <= 1'b1;
        iorq_n <= 1'b1;
        rd_n   <= 1'b1;
        wr_n   <= 1'b1;
        @(posedge clk);
    endtask

    task automatic io_write(input byte_t port, input byte_t data);
        mreq_n        <= 1'b1;
        iorq_n        <= 1'b0;
        rd_n          <= 1'b1;
        wr_n          <= 1'b0;
        cpuaddr       <= {rand_byte(), port};
        data_from_cpu <= data;
        @(posedge clk);
    endtask

    task automatic io_read(input byte_t port);
        mreq_n   <= 1'b1;
        iorq_n   <= 1'b0;
        rd_n     <= 1'b0;
        wr_n     <= 1'b1;
        cpuaddr  <= {rand_byte(), port};
        ear      <= rand_bit();
        keyboard <= rand_byte();
        @(posedge clk);
    endtask

    task automatic memory_cycle();
        logic write;
        write = rand_bit();
        mreq_n  <= rand_bit();
        iorq_n  <= 1'b1;
        rd_n    <= ~write;
        wr_n    <= write;
        cpuaddr <= rand_word();
        @(posedge clk);
    endtask

    // Random memory and I/O cycles without I/O writes
    task automatic random_bus_cycle();
        byte_t low;
        low = rand_bit() ? PORT_LINEINT : rand_byte();
        cpuaddr  <= {rand_byte(), low};
        mreq_n   <= rand_bit();
        iorq_n   <= rand_bit();
        rd_n     <= rand_bit();
        wr_n     <= 1'b1;
        ear      <= rand_bit();
        keyboard <= rand_byte();
        @(posedge clk);
    endtask

    ////////////////////
    // Test sequence

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        mreq_n        = 1'b1;
        iorq_n        = 1'b1;
        rd_n          = 1'b1;
        wr_n          = 1'b1;
        cpuaddr       = '0;
        data_from_cpu = '0;
        ear           = 1'b0;
        keyboard      = 8'hFF;
        checking      = 1'b0;
        test_name     = "reset";
        lfsr_state    = 32'h1e9e_e64b;

        @(posedge clk);
        checking = 1'b1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Next cycle is hc = 0, vc = 0
        test_name = "sync and frame interrupt";
        repeat (FRAME_CYCLES) idle_cycle();

        test_name = "line interrupt and contention";
        line_sel  = rand_byte() % 8'd192;
        for (int line = 0; line < int'(V_TOTAL); line++) begin
            for (int col = 0; col < int'(H_TOTAL); col++) begin
                if (col == 0) begin
                    io_write(PORT_VMPR, rand_byte());
                end else if (col == 1) begin
                    io_write(PORT_BORDER, rand_byte());
                end else if ((col == 2) && (line == 0)) begin
                    io_write(PORT_LINEINT, line_sel);
                end else if ((col == 2) && (line == int'(line_sel) + 1)) begin
                    // Line past the active area turns the line interrupt off
                    io_write(PORT_LINEINT, 8'd200);
                end else begin
                    random_bus_cycle();
                end
            end
        end

        test_name = "register readback";
        repeat (8) begin
            io_write(PORT_VMPR, rand_byte());
            io_write(PORT_HMPR, rand_byte());
            io_write(PORT_LMPR, rand_byte());
            io_read(PORT_VMPR);
            io_read(PORT_HMPR);
            io_read(PORT_LMPR);
            io_write(PORT_BORDER, rand_byte());
            io_read(PORT_BORDER);
            io_read(PORT_LINEINT);
        end
        idle_cycle();

        test_name = "memory mapping";
        repeat (16) begin
            io_write(PORT_LMPR, rand_byte());
            io_write(PORT_HMPR, rand_byte());
            repeat (48) memory_cycle();
        end
        idle_cycle();
        @(posedge clk);

        $display("TEST RESULT: PASS");
        $finish;
    end

    // Watchdog covers two frames plus margin
    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog timeout: the tests did not finish in time");
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped by the watchdog");
    end

endmodule

// ==== sources.f ====
design/asic_pkg.sv
design/raster_timer.sv
design/sync_int_gen.sv
design/contention_gen.sv
design/io_ports.sv
design/mem_mapper.sv
design/asic_top.sv
sim/asic_tb.sv
